// File: replica_ring.f
replica_pkg.sv
host_regs_pkg.sv
opt_route.sv
exchange.sv
exchange_sequencer.sv
wb_host_port.sv
replica_ring.sv
tb_replica_ring.sv

// File: tb_replica_ring.sv
module tb_replica_ring
    import replica_pkg::*, host_regs_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int clk_half       = 20;
localparam int drive_delay    = 2;
localparam int timeout_cycles = 15000;

typedef city_t [city_num-1:0] tour_t;
typedef tour_t [replica_num-1:0] ring_t;

logic                    clk;
logic                    reset;
logic                    wb_cyc;
logic                    wb_stb;
logic                    wb_we;
logic [wb_adr_width-1:0] wb_adr;
logic [wb_dat_width-1:0] wb_dat_w;
logic [wb_dat_width-1:0] wb_dat_r;
logic                    wb_ack;

ring_t  model;
integer seed;
int     cycle_count = 0;

replica_ring u_replica_ring (
    .clk      ( clk      ),
    .reset    ( reset    ),
    .wb_cyc_i ( wb_cyc   ),
    .wb_stb_i ( wb_stb   ),
    .wb_we_i  ( wb_we    ),
    .wb_adr_i ( wb_adr   ),
    .wb_dat_i ( wb_dat_w ),
    .wb_dat_o ( wb_dat_r ),
    .wb_ack_o ( wb_ack   )
);

always #clk_half clk = ~clk;

task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first error");
endtask

always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles)
        stop_with_failure("timeout: run did not finish");
end

task automatic check_value(input string test, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual)
        stop_with_failure($sformatf("mismatch %s expected %0d actual %0d",
                                    test, expected, actual));
endtask

// Tour after a word move built one position at a time
function automatic tour_t move_tour(tour_t t, opt_kind_t kind, int a, int b);
    tour_t m;
    int    w;
    int    e;
    int    src;
    for (int p = 0; p < city_num; p++) begin
        w   = p / word_cities;
        e   = p % word_cities;
        src = p;
        case (kind)
            OPT_SWAP: begin
                if (w == a)
                    src = b * word_cities + e;
                else if (w == b)
                    src = a * word_cities + e;
            end
            OPT_REVERSE: begin
                if (p >= a * word_cities && p <= b * word_cities + word_cities - 1)
                    src = a * word_cities + b * word_cities + word_cities - 1 - p;
            end
            default: ;
        endcase
        m[p] = t[src];
    end
    return m;
endfunction

function automatic ring_t apply_step(ring_t cur, exchange_command_t [replica_num-1:0] cmds,
                                     opt_kind_t kind, int a, int b);
    ring_t outs;
    ring_t nxt;
    for (int r = 0; r < replica_num; r++) begin
        outs[r] = move_tour(cur[r], kind, a, b);
    end
    for (int r = 0; r < replica_num; r++) begin
        case (cmds[r])
            PREV:    nxt[r] = outs[(r + replica_num - 1) % replica_num];
            FOLW:    nxt[r] = outs[(r + 1) % replica_num];
            SELF:    nxt[r] = outs[r];
            default: nxt[r] = cur[r];
        endcase
    end
    return nxt;
endfunction

function automatic exchange_command_t [replica_num-1:0] make_cmds(
    exchange_command_t c0, exchange_command_t c1, exchange_command_t c2);
    exchange_command_t [replica_num-1:0] c;
    c[0] = c0;
    c[1] = c1;
    c[2] = c2;
    return c;
endfunction

task automatic wb_write(input logic [wb_adr_width-1:0] adr, input logic [wb_dat_width-1:0] dat);
    @(posedge clk);
    #drive_delay;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = dat;
    @(negedge clk);
    while (!wb_ack)
        @(negedge clk);
    @(posedge clk);
    #drive_delay;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
endtask

task automatic wb_read(input logic [wb_adr_width-1:0] adr, output logic [wb_dat_width-1:0] dat);
    @(posedge clk);
    #drive_delay;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    @(negedge clk);
    while (!wb_ack)
        @(negedge clk);
    dat = wb_dat_r;
    @(posedge clk);
    #drive_delay;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
endtask

task automatic read_city(input int r, input int p, output logic [wb_dat_width-1:0] dat);
    wb_read(reg_order_base + wb_adr_width'(r * city_num + p), dat);
endtask

task automatic random_tour(output tour_t t);
    int    j;
    city_t tmp;
    for (int p = 0; p < city_num; p++) begin
        t[p] = city_t'(p);
    end
    for (int i = city_num - 1; i > 0; i--) begin
        j    = $unsigned($random(seed)) % (i + 1);
        tmp  = t[i];
        t[i] = t[j];
        t[j] = tmp;
    end
endtask

// Each word goes out as LOAD_LO then LOAD_HI
task automatic load_tour(input int r, input tour_t t);
    logic [wb_dat_width-1:0] lo;
    logic [wb_dat_width-1:0] hi;
    for (int w = 0; w < city_div; w++) begin
        lo = '0;
        hi = '0;
        for (int e = 0; e < load_cities; e++) begin
            lo[city_num_log*e +: city_num_log] = t[w * word_cities + e];
            hi[city_num_log*e +: city_num_log] = t[w * word_cities + load_cities + e];
        end
        hi[load_sel_lsb +: replica_sel_width] = replica_sel_width'(r);
        wb_write(reg_load_lo, lo);
        wb_write(reg_load_hi, hi);
    end
endtask

task automatic start_step(input exchange_command_t [replica_num-1:0] cmds,
                          input opt_kind_t kind, input int a, input int b);
    logic [wb_dat_width-1:0] ctrl;
    ctrl = '0;
    for (int r = 0; r < replica_num; r++) begin
        ctrl[ctrl_cmd_width*r +: ctrl_cmd_width] = cmds[r];
    end
    ctrl[ctrl_opt_lsb +: city_div_log]                  = city_div_log'(b);
    ctrl[ctrl_opt_lsb + city_div_log +: city_div_log]   = city_div_log'(a);
    ctrl[ctrl_opt_lsb + 2 * city_div_log +: 2]          = kind;
    ctrl[ctrl_start_bit]                                = 1'b1;
    wb_write(reg_ctrl, ctrl);
    model = apply_step(model, cmds, kind, a, b);
endtask

task automatic wait_idle();
    logic [wb_dat_width-1:0] status;
    wb_read(reg_status, status);
    while (status != 0)
        wb_read(reg_status, status);
endtask

task automatic compare_ring(input string test);
    logic [wb_dat_width-1:0] dat;
    for (int r = 0; r < replica_num; r++) begin
        for (int p = 0; p < city_num; p++) begin
            read_city(r, p, dat);
            check_value(test, model[r][p], dat);
        end
    end
endtask

task automatic run_step(input string test, input exchange_command_t [replica_num-1:0] cmds,
                        input opt_kind_t kind, input int a, input int b);
    start_step(cmds, kind, a, b);
    wait_idle();
    compare_ring(test);
endtask

initial begin
    tour_t                               t;
    logic [wb_dat_width-1:0]             status;
    logic [wb_dat_width-1:0]             prev_status;
    logic [wb_dat_width-1:0]             dat;
    exchange_command_t [replica_num-1:0] cmds;
    opt_kind_t                           kind;
    int                                  a;
    int                                  b;
    int                                  tmp;

    seed     = 32'h3b84;
    clk      = 1'b0;
    reset    = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    repeat (3) @(posedge clk);
    #drive_delay;
    reset = 1'b0;

    // Loaded tours land in the spare bank and show after the flip
    for (int r = 0; r < replica_num; r++) begin
        random_tour(t);
        model[r] = t;
        load_tour(r, t);
    end
    wb_write(reg_ctrl, 32'(1) << ctrl_flip_bit);
    compare_ring("load");

    run_step("self none", make_cmds(SELF, SELF, SELF), OPT_NONE, 0, 0);
    run_step("self swap 0 3", make_cmds(SELF, SELF, SELF), OPT_SWAP, 0, 3);
    run_step("self swap 2 1", make_cmds(SELF, SELF, SELF), OPT_SWAP, 2, 1);
    run_step("self reverse 0 3", make_cmds(SELF, SELF, SELF), OPT_REVERSE, 0, 3);
    run_step("self reverse 1 2", make_cmds(SELF, SELF, SELF), OPT_REVERSE, 1, 2);
    run_step("self reverse 2 2", make_cmds(SELF, SELF, SELF), OPT_REVERSE, 2, 2);

    run_step("neighbour swap", make_cmds(FOLW, PREV, SELF), OPT_NONE, 0, 0);
    run_step("rotation", make_cmds(PREV, PREV, PREV), OPT_NONE, 0, 0);

    for (int i = 0; i < 10; i++) begin
        for (int r = 0; r < replica_num; r++) begin
            cmds[r] = exchange_command_t'(1 + $unsigned($random(seed)) % 3);
        end
        kind = opt_kind_t'($unsigned($random(seed)) % 3);
        a    = $unsigned($random(seed)) % city_div;
        b    = $unsigned($random(seed)) % city_div;
        if (kind == OPT_REVERSE && a > b) begin
            tmp = a;
            a   = b;
            b   = tmp;
        end
        run_step($sformatf("random step %0d", i), cmds, kind, a, b);
    end

    // Busy shows on the first poll and clears for good within 10 polls
    start_step(make_cmds(SELF, FOLW, PREV), OPT_REVERSE, 0, 2);
    for (int i = 0; i < 10; i++) begin
        wb_read(reg_status, status);
        if (i == 0)
            check_value("status poll busy", 1, status);
        else if (prev_status == 0)
            check_value("status poll idle", 0, status);
        prev_status = status;
    end
    wb_read(reg_status, status);
    check_value("status idle", 0, status);
    compare_ring("busy step");

    // This read is held until the step completes
    start_step(make_cmds(FOLW, PREV, SELF), OPT_SWAP, 1, 3);
    read_city(1, 5, dat);
    check_value("read during busy", model[1][5], dat);
    wait_idle();
    compare_ring("held read step");

    $display("STATUS: PASS");
    $finish;
end

endmodule

// File: replica_ring.sv
module replica_ring
    import replica_pkg::*, host_regs_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    wb_cyc_i,
    input  logic                    wb_stb_i,
    input  logic                    wb_we_i,
    input  logic [wb_adr_width-1:0] wb_adr_i,
    input  logic [wb_dat_width-1:0] wb_dat_i,
    output logic [wb_dat_width-1:0] wb_dat_o,
    output logic                    wb_ack_o
);

logic                                step_req, flip_req, load_valid, ordering_read;
logic                                exchange_bank, busy;
exchange_command_t [replica_num-1:0] cmd_req, command;
opt_t                                opt_req, opt;
logic [replica_sel_width-1:0]        load_sel;
replica_data_t                       load_data;
logic [city_num_log-1:0]             ordering_addr;
city_t [replica_num-1:0]             ordering_data;
logic [replica_num-1:0]              out_valid;
replica_data_t [replica_num-1:0]     out_data;

wb_host_port u_wb_host_port (
    .clk             ( clk           ),
    .reset           ( reset         ),
    .wb_cyc_i        ( wb_cyc_i      ),
    .wb_stb_i        ( wb_stb_i      ),
    .wb_we_i         ( wb_we_i       ),
    .wb_adr_i        ( wb_adr_i      ),
    .wb_dat_i        ( wb_dat_i      ),
    .wb_dat_o        ( wb_dat_o      ),
    .wb_ack_o        ( wb_ack_o      ),
    .busy_i          ( busy          ),
    .ordering_data_i ( ordering_data ),
    .step_req_o      ( step_req      ),
    .flip_req_o      ( flip_req      ),
    .cmd_req_o       ( cmd_req       ),
    .opt_req_o       ( opt_req       ),
    .load_valid_o    ( load_valid    ),
    .load_sel_o      ( load_sel      ),
    .load_data_o     ( load_data     ),
    .ordering_read_o ( ordering_read ),
    .ordering_addr_o ( ordering_addr )
);

exchange_sequencer u_exchange_sequencer (
    .clk             ( clk           ),
    .reset           ( reset         ),
    .step_req_i      ( step_req      ),
    .flip_req_i      ( flip_req      ),
    .cmd_req_i       ( cmd_req       ),
    .opt_req_i       ( opt_req       ),
    .load_valid_i    ( load_valid    ),
    .load_sel_i      ( load_sel      ),
    .command_o       ( command       ),
    .opt_o           ( opt           ),
    .exchange_bank_o ( exchange_bank ),
    .busy_o          ( busy          )
);

// Neighbours close the ring modulo replica_num
for (genvar r = 0; r < replica_num; r++) begin : g_replica
    exchange u_exchange (
        .clk             ( clk                                          ),
        .reset           ( reset                                        ),
        .command_i       ( command[r]                                   ),
        .opt_i           ( opt                                          ),
        .exchange_bank_i ( exchange_bank                                ),
        .prev_valid_i    ( out_valid[(r + replica_num - 1) % replica_num] ),
        .prev_data_i     ( out_data[(r + replica_num - 1) % replica_num]  ),
        .folw_valid_i    ( out_valid[(r + 1) % replica_num]             ),
        .folw_data_i     ( out_data[(r + 1) % replica_num]              ),
        .load_valid_i    ( load_valid                                   ),
        .load_data_i     ( load_data                                    ),
        .ordering_read_i ( ordering_read                                ),
        .ordering_addr_i ( ordering_addr                                ),
        .out_valid_o     ( out_valid[r]                                 ),
        .out_data_o      ( out_data[r]                                  ),
        .ordering_data_o ( ordering_data[r]                             )
    );
end

endmodule

// File: wb_host_port.sv
module wb_host_port
    import replica_pkg::*, host_regs_pkg::*;
(
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wb_cyc_i,
    input  logic                                wb_stb_i,
    input  logic                                wb_we_i,
    input  logic [wb_adr_width-1:0]             wb_adr_i,
    input  logic [wb_dat_width-1:0]             wb_dat_i,
    output logic [wb_dat_width-1:0]             wb_dat_o,
    output logic                                wb_ack_o,
    input  logic                                busy_i,
    input  city_t [replica_num-1:0]             ordering_data_i,
    output logic                                step_req_o,
    output logic                                flip_req_o,
    output exchange_command_t [replica_num-1:0] cmd_req_o,
    output opt_t                                opt_req_o,
    output logic                                load_valid_o,
    output logic [replica_sel_width-1:0]        load_sel_o,
    output replica_data_t                       load_data_o,
    output logic                                ordering_read_o,
    output logic [city_num_log-1:0]             ordering_addr_o
);

typedef enum logic [1:0] {
    IDLE,
    WAIT_RD,
    ACK
} port_state_t;

port_state_t                  state;
logic                         req, is_order, hold, accept, wait_cnt;
logic                         wr_ctrl, wr_load_lo, wr_load_hi;
logic [wb_adr_width-1:0]      order_off;
logic [replica_sel_width-1:0] rd_sel;
logic [load_bits-1:0]         load_lo;

assign req       = wb_cyc_i && wb_stb_i && state == IDLE;
assign order_off = wb_adr_i - reg_order_base;
assign is_order  = wb_adr_i >= reg_order_base && order_off < order_span;

// CTRL, LOAD_HI and ordering reads wait for the step to finish
assign hold   = busy_i && (wb_we_i ? (wb_adr_i == reg_ctrl || wb_adr_i == reg_load_hi) : is_order);
assign accept = req && !hold;

assign wr_ctrl    = accept && wb_we_i && wb_adr_i == reg_ctrl;
assign wr_load_lo = accept && wb_we_i && wb_adr_i == reg_load_lo;
assign wr_load_hi = accept && wb_we_i && wb_adr_i == reg_load_hi;

assign ordering_read_o = accept && !wb_we_i && is_order;
assign ordering_addr_o = order_off[city_num_log-1:0];
assign wb_ack_o        = state == ACK;

always_ff @(posedge clk) begin
    if (reset) begin
        state        <= IDLE;
        wait_cnt     <= 1'b0;
        step_req_o   <= 1'b0;
        flip_req_o   <= 1'b0;
        load_valid_o <= 1'b0;
    end else begin
        step_req_o   <= wr_ctrl && wb_dat_i[ctrl_start_bit];
        flip_req_o   <= wr_ctrl && wb_dat_i[ctrl_flip_bit];
        load_valid_o <= wr_load_hi;
        case (state)
            IDLE: begin
                wait_cnt <= 1'b0;
                if (accept)
                    state <= ordering_read_o ? WAIT_RD : ACK;
            end
            WAIT_RD: begin
                // Exchange RAM plus city select take two cycles
                wait_cnt <= 1'b1;
                if (wait_cnt)
                    state <= ACK;
            end
            default: state <= IDLE;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (wr_ctrl) begin
        for (int r = 0; r < replica_num; r++) begin
            cmd_req_o[r] <= exchange_command_t'(wb_dat_i[ctrl_cmd_width*r +: ctrl_cmd_width]);
        end
        opt_req_o <= opt_t'(wb_dat_i[ctrl_opt_lsb +: $bits(opt_t)]);
    end
    if (wr_load_lo)
        load_lo <= wb_dat_i[load_bits-1:0];
    if (wr_load_hi) begin
        load_data_o <= {wb_dat_i[load_bits-1:0], load_lo};
        load_sel_o  <= wb_dat_i[load_sel_lsb +: replica_sel_width];
    end
    if (ordering_read_o)
        rd_sel <= order_off[city_num_log +: replica_sel_width];
    if (accept && !wb_we_i && !is_order)
        wb_dat_o <= (wb_adr_i == reg_status) ? wb_dat_width'(busy_i) : '0;
    else if (state == WAIT_RD && wait_cnt)
        wb_dat_o <= wb_dat_width'(ordering_data_i[rd_sel]);
end

endmodule

// File: exchange_sequencer.sv
module exchange_sequencer
    import replica_pkg::*, host_regs_pkg::*;
(
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                step_req_i,
    input  logic                                flip_req_i,
    input  exchange_command_t [replica_num-1:0] cmd_req_i,
    input  opt_t                                opt_req_i,
    input  logic                                load_valid_i,
    input  logic [replica_sel_width-1:0]        load_sel_i,
    output exchange_command_t [replica_num-1:0] command_o,
    output opt_t                                opt_o,
    output logic                                exchange_bank_o,
    output logic                                busy_o
);

typedef enum logic {
    IDLE,
    STEP
} seq_state_t;

seq_state_t                         state;
logic [$clog2(step_cycles+1)-1:0]   step_cnt;

assign busy_o = state == STEP;

always_ff @(posedge clk) begin
    if (reset) begin
        state           <= IDLE;
        step_cnt        <= '0;
        exchange_bank_o <= 1'b0;
        for (int r = 0; r < replica_num; r++) begin
            command_o[r] <= NOP;
        end
    end else begin
        // Commands last a single cycle
        for (int r = 0; r < replica_num; r++) begin
            command_o[r] <= NOP;
        end
        case (state)
            IDLE: begin
                if (step_req_i) begin
                    state     <= STEP;
                    step_cnt  <= 1;
                    command_o <= cmd_req_i;
                end else if (load_valid_i) begin
                    command_o[load_sel_i] <= LOAD;
                end
                if (flip_req_i)
                    exchange_bank_o <= ~exchange_bank_o;
            end
            default: begin
                // New tours become current in the last busy cycle
                if (step_cnt == step_cycles) begin
                    state           <= IDLE;
                    exchange_bank_o <= ~exchange_bank_o;
                end
                step_cnt <= step_cnt + 1'b1;
            end
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state == IDLE && step_req_i)
        opt_o <= opt_req_i;
end

for (genvar r = 0; r < replica_num; r++) begin : g_cmd_check
    a_step_cmd: assert property (@(posedge clk) disable iff (reset)
        step_req_i |-> !(cmd_req_i[r] inside {NOP, LOAD}));
end

a_no_req_busy: assert property (@(posedge clk) disable iff (reset)
    busy_o |-> !(step_req_i || load_valid_i));

endmodule

// File: exchange.sv
module exchange
    import replica_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  exchange_command_t       command_i,
    input  opt_t                    opt_i,
    input  logic                    exchange_bank_i,
    input  logic                    prev_valid_i,
    input  replica_data_t           prev_data_i,
    input  logic                    folw_valid_i,
    input  replica_data_t           folw_data_i,
    input  logic                    load_valid_i,
    input  replica_data_t           load_data_i,
    input  logic                    ordering_read_i,
    input  logic [city_num_log-1:0] ordering_addr_i,
    output logic                    out_valid_o,
    output replica_data_t           out_data_o,
    output city_t                   ordering_data_o
);

replica_data_t ram [2][city_div];

logic [city_div_log-1:0]              rcount, raddr, wcount;
exchange_command_t                    command_d1, command_d2, command_d3;
logic                                 command_nop_d;
logic                                 wbank_d1, wbank_d2, wbank_d3;
opt_t                                 opt_d1;
replica_data_t                        out_data_r, out_data_d;
logic                                 route_valid;
replica_data_t                        route_data;
replica_data_t                        load_word;
logic [city_num_log-city_div_log-1:0] ordering_sel;

logic          load_wr, step_wr, write_en, write_bank;
replica_data_t write_data;

always_comb begin
    step_wr    = 1'b0;
    write_data = out_data_o;
    case (command_d3)
        PREV: begin
            step_wr    = prev_valid_i;
            write_data = prev_data_i;
        end
        FOLW: begin
            step_wr    = folw_valid_i;
            write_data = folw_data_i;
        end
        SELF: step_wr = out_valid_o;
        default: ;
    endcase
    // Host word goes straight to the spare bank
    load_wr = command_i == LOAD;
    if (load_wr)
        write_data = load_word;
end

assign write_en   = step_wr || load_wr;
assign write_bank = load_wr ? ~exchange_bank_i : wbank_d3;

// Ordering reads take the port while no step runs
assign raddr = ordering_read_i ? ordering_addr_i[city_num_log-1 -: city_div_log] : rcount;

always_ff @(posedge clk) begin
    if (write_en)
        ram[write_bank][wcount] <= write_data;
    out_data_r <= ram[exchange_bank_i][raddr];
end

always_ff @(posedge clk) begin
    if (reset) begin
        command_d1    <= NOP;
        command_d2    <= NOP;
        command_d3    <= NOP;
        command_nop_d <= 1'b1;
        out_valid_o   <= 1'b0;
        wcount        <= '0;
    end else begin
        if (command_i != NOP && command_i != LOAD)
            command_d1 <= command_i;
        command_d2    <= command_d1;
        command_d3    <= command_d2;
        command_nop_d <= command_i == NOP;
        out_valid_o   <= route_valid;
        if (write_en)
            wcount <= (wcount == city_div_log'(city_div - 1)) ? '0 : wcount + 1'b1;
    end
end

always_ff @(posedge clk) begin
    wbank_d1   <= ~exchange_bank_i;
    wbank_d2   <= wbank_d1;
    wbank_d3   <= wbank_d2;
    opt_d1     <= opt_i;
    out_data_d <= out_data_r;
    out_data_o <= route_data;
    if (load_valid_i)
        load_word <= load_data_i;
    ordering_sel    <= ordering_addr_i[city_num_log-city_div_log-1:0];
    ordering_data_o <= out_data_r[ordering_sel];
end

opt_route u_opt_route (
    .clk             ( clk           ),
    .reset           ( reset         ),
    .command_i       ( command_i     ),
    .command_nop_d_i ( command_nop_d ),
    .opt_i           ( opt_i         ),
    .opt_d_i         ( opt_d1        ),
    .out_data_i      ( out_data_d    ),
    .rcount_o        ( rcount        ),
    .out_valid_o     ( route_valid   ),
    .out_data_o      ( route_data    )
);

a_read_outside_step: assert property (@(posedge clk) disable iff (reset)
    ordering_read_i |-> !out_valid_o);

endmodule

// File: opt_route.sv
module opt_route
    import replica_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  exchange_command_t       command_i,
    input  logic                    command_nop_d_i,
    input  opt_t                    opt_i,
    input  opt_t                    opt_d_i,
    input  replica_data_t           out_data_i,
    output logic [city_div_log-1:0] rcount_o,
    output logic                    out_valid_o,
    output replica_data_t           out_data_o
);

logic                    start;
logic                    run;
logic [city_div_log-1:0] slot;
logic                    rev_word;
logic [1:0]              valid_sr;
logic [1:0]              rev_sr;

// Word read for output slot k under a move
function automatic logic [city_div_log-1:0] word_addr(opt_t o, logic [city_div_log-1:0] k);
    logic [city_div_log-1:0] w;
    w = k;
    case (o.kind)
        OPT_SWAP: begin
            if (k == o.a)
                w = o.b;
            else if (k == o.b)
                w = o.a;
        end
        OPT_REVERSE: begin
            if (k >= o.a && k <= o.b)
                w = o.a + o.b - k;
        end
        default: ;
    endcase
    return w;
endfunction

function automatic replica_data_t flip_word(replica_data_t d);
    replica_data_t f;
    for (int e = 0; e < word_cities; e++) begin
        f[e] = d[word_cities-1-e];
    end
    return f;
endfunction

// A step begins on the first non-NOP cycle
assign start = command_nop_d_i && command_i != NOP && command_i != LOAD;

assign rcount_o = word_addr(opt_i, slot);

assign rev_word = run && opt_d_i.kind == OPT_REVERSE && slot >= opt_d_i.a && slot <= opt_d_i.b;

always_ff @(posedge clk) begin
    if (reset) begin
        run      <= 1'b0;
        slot     <= '0;
        valid_sr <= '0;
        out_valid_o <= 1'b0;
    end else begin
        if (start) begin
            run  <= 1'b1;
            slot <= '0;
        end else if (run) begin
            if (slot == city_div_log'(city_div - 1))
                run <= 1'b0;
            slot <= slot + 1'b1;
        end
        // RAM read and delay stage
        valid_sr    <= {valid_sr[0], run};
        out_valid_o <= valid_sr[1];
    end
end

always_ff @(posedge clk) begin
    rev_sr     <= {rev_sr[0], rev_word};
    out_data_o <= rev_sr[1] ? flip_word(out_data_i) : out_data_i;
end

a_reverse_range: assert property (@(posedge clk) disable iff (reset)
    start |-> (opt_i.kind != OPT_REVERSE || opt_i.a <= opt_i.b));

endmodule

// File: host_regs_pkg.sv
package host_regs_pkg;

import replica_pkg::*;

localparam int wb_adr_width = 8;
localparam int wb_dat_width = 32;

localparam logic [wb_adr_width-1:0] reg_ctrl       = 8'h00;
localparam logic [wb_adr_width-1:0] reg_status     = 8'h01;
localparam logic [wb_adr_width-1:0] reg_load_lo    = 8'h02;
localparam logic [wb_adr_width-1:0] reg_load_hi    = 8'h03;
localparam logic [wb_adr_width-1:0] reg_order_base = 8'h40;

// Ordering window covers every city of every replica
localparam int order_span = replica_num * city_num;

// CTRL fields
localparam int ctrl_cmd_width = 3;
localparam int ctrl_opt_lsb   = 9;
localparam int ctrl_start_bit = 16;
localparam int ctrl_flip_bit  = 17;

// LOAD_LO and LOAD_HI each carry half a word
localparam int load_cities       = 4;
localparam int load_bits         = load_cities * city_num_log;
localparam int load_sel_lsb      = 24;
localparam int replica_sel_width = 2;

localparam int step_cycles = city_div + 6;

endpackage

// File: replica_pkg.sv
package replica_pkg;

// Tour geometry
localparam int city_num     = 32;
localparam int city_num_log = 5;
localparam int city_div     = 4;
localparam int city_div_log = 2;
localparam int replica_num  = 3;

// Cities held in one RAM word
localparam int word_cities  = city_num / city_div;

typedef logic [city_num_log-1:0] city_t;

// Element 0 is the lowest tour position inside the word
typedef city_t [word_cities-1:0] replica_data_t;

// Source of the next tour for one replica
typedef enum logic [2:0] {
    NOP,
    PREV,
    FOLW,
    SELF,
    LOAD
} exchange_command_t;

// Word-granular moves
// OPT_SWAP exchanges words a and b
// OPT_REVERSE reverses positions 8a to 8b+7 and needs a <= b
typedef enum logic [1:0] {
    OPT_NONE,
    OPT_SWAP,
    OPT_REVERSE
} opt_kind_t;

typedef struct packed {
    opt_kind_t               kind;
    logic [city_div_log-1:0] a;
    logic [city_div_log-1:0] b;
} opt_t;

endpackage
